//--- common/dir_resp_if.sv
/*
 * Request passed from the directory stage to the response stage,
 * with the victim state and the previous L1 directory entry.
 */

`timescale 1ns/1ps

interface dir_resp_if;
	import l2_pkg::*;

	logic valid;
	pci_op_t op;
	l2_addr_t address;
	logic hit;
	// Hit way on a hit, replacement way otherwise
	way_t way;
	logic victim_valid;
	l2_tag_t victim_tag;
	logic victim_dirty;
	logic l1_valid;
	way_t l1_way;
	l2_tag_t l1_tag;

	modport src(
		output valid, op, address, hit, way,
		output victim_valid, victim_tag, victim_dirty,
		output l1_valid, l1_way, l1_tag
	);

	modport dst(
		input valid, op, address, hit, way,
		input victim_valid, victim_tag, victim_dirty,
		input l1_valid, l1_way, l1_tag
	);

endinterface

//--- common/l2_pkg.sv
/*
 * Shared definitions for the L2 directory pipeline: cache sizes,
 * the line address split into set and tag, and the request operation
 * and response status encodings.
 */

package l2_pkg;

	localparam int l2_num_sets = 16;
	localparam int l2_num_ways = 4;
	localparam int l2_set_width = 4;
	localparam int l2_tag_width = 6;
	localparam int addr_width = l2_set_width + l2_tag_width;

	typedef logic [1:0] way_t;
	typedef logic [l2_tag_width - 1:0] l2_tag_t;
	typedef logic [l2_set_width - 1:0] l2_set_t;
	typedef logic [addr_width - 1:0] l2_addr_t;

	typedef enum logic [1:0] {
		op_load,
		op_store,
		op_fill
	} pci_op_t;

	typedef enum logic [1:0] {
		status_hit,
		status_miss,
		status_fill,
		status_fill_writeback
	} resp_status_t;

	// The set index sits in the low bits of a line address
	function automatic l2_set_t addr_set(input l2_addr_t address);
		return address[l2_set_width - 1:0];
	endfunction

	function automatic l2_tag_t addr_tag(input l2_addr_t address);
		return address[addr_width - 1:l2_set_width];
	endfunction

endpackage

//--- common/tag_dir_if.sv
/*
 * Decoded request passed from the tag stage to the directory stage,
 * with the hit result and the chosen replacement victim.
 */

`timescale 1ns/1ps

interface tag_dir_if;
	import l2_pkg::*;

	logic valid;
	pci_op_t op;
	l2_addr_t address;
	way_t l1_way;
	logic hit;
	way_t hit_way;
	way_t replace_way;
	logic victim_valid;
	l2_tag_t victim_tag;

	modport src(
		output valid, op, address, l1_way,
		output hit, hit_way, replace_way,
		output victim_valid, victim_tag
	);

	modport dst(
		input valid, op, address, l1_way,
		input hit, hit_way, replace_way,
		input victim_valid, victim_tag
	);

endinterface

//--- l2_cache/l2_dir_stage.sv
/*
 * Directory stage: per-line dirty bits and L1 directory entries.
 * Old values are read and forwarded in the same cycle the entry
 * for the request is updated.
 */

`timescale 1ns/1ps

module l2_dir_stage(
	input            clk,
	input            reset,
	input            stall_pipeline,
	tag_dir_if.dst   from_tag,
	dir_resp_if.src  to_resp);

	import l2_pkg::*;

	logic dirty_mem[l2_num_sets][l2_num_ways];

	// Each L2 line has a directory entry with its L1 valid bit, L1 way and tag
	logic dir_valid_mem[l2_num_sets][l2_num_ways];
	way_t dir_l1_way_mem[l2_num_sets][l2_num_ways];
	l2_tag_t dir_l1_tag_mem[l2_num_sets][l2_num_ways];

	l2_set_t req_set;
	l2_tag_t req_tag;
	way_t line_way;
	logic set_dirty;
	logic clear_dirty;
	logic write_entry;

	assign req_set = addr_set(from_tag.address);
	assign req_tag = addr_tag(from_tag.address);
	assign line_way = from_tag.hit ? from_tag.hit_way : from_tag.replace_way;

	assign set_dirty = from_tag.valid && from_tag.op == op_store && from_tag.hit;
	assign clear_dirty = from_tag.valid && from_tag.op == op_fill && !from_tag.hit;
	assign write_entry = from_tag.valid && (from_tag.hit || from_tag.op == op_fill);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			to_resp.valid <= 1'b0;
			for (int s = 0; s < l2_num_sets; s++)
			begin
				for (int w = 0; w < l2_num_ways; w++)
				begin
					dirty_mem[s][w] <= 1'b0;
					dir_valid_mem[s][w] <= 1'b0;
				end
			end
		end
		else if (!stall_pipeline)
		begin
			to_resp.valid <= from_tag.valid;

			// A store only dirties a line that is resident
			if (set_dirty)
				dirty_mem[req_set][from_tag.hit_way] <= 1'b1;
			else if (clear_dirty)
				dirty_mem[req_set][from_tag.replace_way] <= 1'b0;

			if (write_entry)
				dir_valid_mem[req_set][line_way] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			if (write_entry)
			begin
				dir_l1_way_mem[req_set][line_way] <= from_tag.l1_way;
				dir_l1_tag_mem[req_set][line_way] <= req_tag;
			end

			to_resp.op <= from_tag.op;
			to_resp.address <= from_tag.address;
			to_resp.hit <= from_tag.hit;
			to_resp.way <= line_way;
			to_resp.victim_valid <= from_tag.victim_valid;
			to_resp.victim_tag <= from_tag.victim_tag;
			to_resp.victim_dirty <= dirty_mem[req_set][from_tag.replace_way];

			// The previous entry of the chosen line is read before this update lands
			to_resp.l1_valid <= dir_valid_mem[req_set][line_way];
			to_resp.l1_way <= dir_l1_way_mem[req_set][line_way];
			to_resp.l1_tag <= dir_l1_tag_mem[req_set][line_way];
		end
	end

endmodule

//--- l2_cache/l2_response_stage.sv
/*
 * Response stage: classifies hit, miss, fill and dirty writeback,
 * and holds the response register.
 */

`timescale 1ns/1ps

module l2_response_stage(
	input                              clk,
	input                              reset,
	input                              stall_pipeline,
	dir_resp_if.dst                    from_dir,
	output logic                       resp_valid,
	output l2_pkg::pci_op_t            resp_op,
	output l2_pkg::l2_addr_t           resp_address,
	output l2_pkg::resp_status_t       resp_status,
	output l2_pkg::way_t               resp_way,
	output l2_pkg::l2_tag_t            resp_evict_tag,
	output logic                       resp_l1_valid,
	output l2_pkg::way_t               resp_l1_way,
	output l2_pkg::l2_tag_t            resp_l1_tag);

	import l2_pkg::*;

	resp_status_t status;

	always_comb
	begin
		if (from_dir.hit)
			status = status_hit;
		else if (from_dir.op == op_fill)
		begin
			// Only a dirty resident victim needs to go back to memory
			if (from_dir.victim_valid && from_dir.victim_dirty)
				status = status_fill_writeback;
			else
				status = status_fill;
		end
		else
			status = status_miss;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			resp_valid <= 1'b0;
		else if (!stall_pipeline)
			resp_valid <= from_dir.valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			resp_op <= from_dir.op;
			resp_address <= from_dir.address;
			resp_status <= status;
			resp_way <= from_dir.way;
			resp_evict_tag <= status == status_fill_writeback ? from_dir.victim_tag : '0;
			resp_l1_valid <= from_dir.l1_valid;
			resp_l1_way <= from_dir.l1_way;
			resp_l1_tag <= from_dir.l1_tag;
		end
	end

endmodule

//--- l2_cache/l2_tag_stage.sv
/*
 * Tag stage: request register, four-way tag lookup over the sets,
 * per-set round-robin replacement and tag install on a fill miss.
 */

`timescale 1ns/1ps

module l2_tag_stage(
	input                    clk,
	input                    reset,
	input                    stall_pipeline,
	input                    req_valid,
	input l2_pkg::pci_op_t   req_op,
	input l2_pkg::l2_addr_t  req_address,
	input l2_pkg::way_t      req_l1_way,
	tag_dir_if.src           to_dir);

	import l2_pkg::*;

	// The lookup works on a registered copy of the incoming request
	logic req_valid_q;
	pci_op_t req_op_q;
	l2_addr_t req_address_q;
	way_t req_l1_way_q;

	l2_tag_t tag_mem[l2_num_sets][l2_num_ways];
	logic valid_mem[l2_num_sets][l2_num_ways];
	way_t rr_count[l2_num_sets];

	l2_set_t req_set;
	l2_tag_t req_tag;
	logic hit;
	way_t hit_way;
	way_t replace_way;
	logic install;

	assign req_set = addr_set(req_address_q);
	assign req_tag = addr_tag(req_address_q);
	assign replace_way = rr_count[req_set];

	always_comb
	begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < l2_num_ways; w++)
		begin
			if (!hit && valid_mem[req_set][w] && tag_mem[req_set][w] == req_tag)
			begin
				hit = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	// A fill that already hits keeps the resident line
	assign install = req_valid_q && req_op_q == op_fill && !hit;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			req_valid_q <= 1'b0;
			to_dir.valid <= 1'b0;
			for (int s = 0; s < l2_num_sets; s++)
			begin
				rr_count[s] <= '0;
				for (int w = 0; w < l2_num_ways; w++)
					valid_mem[s][w] <= 1'b0;
			end
		end
		else if (!stall_pipeline)
		begin
			req_valid_q <= req_valid;
			to_dir.valid <= req_valid_q;
			if (install)
			begin
				valid_mem[req_set][replace_way] <= 1'b1;
				rr_count[req_set] <= replace_way + 2'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			req_op_q <= req_op;
			req_address_q <= req_address;
			req_l1_way_q <= req_l1_way;
			if (install)
				tag_mem[req_set][replace_way] <= req_tag;

			to_dir.op <= req_op_q;
			to_dir.address <= req_address_q;
			to_dir.l1_way <= req_l1_way_q;
			to_dir.hit <= hit;
			to_dir.hit_way <= hit_way;
			to_dir.replace_way <= replace_way;
			// Victim state as it was before this request's install
			to_dir.victim_valid <= valid_mem[req_set][replace_way];
			to_dir.victim_tag <= tag_mem[req_set][replace_way];
		end
	end

endmodule

//--- l2_dir.f
common/l2_pkg.sv
common/tag_dir_if.sv
common/dir_resp_if.sv
l2_cache/l2_tag_stage.sv
l2_cache/l2_dir_stage.sv
l2_cache/l2_response_stage.sv
rtl/l2_dir_top.sv
tests/tb_clock_gen.sv
tests/l2_dir_tb.sv

//--- rtl/l2_dir_top.sv
/*
 * Top level of the L2 directory pipeline: tag, directory and
 * response stages joined by their stage interfaces.
 */

`timescale 1ns/1ps

module l2_dir_top(
	input                              clk,
	input                              reset,
	input                              stall_pipeline,
	input                              req_valid,
	input l2_pkg::pci_op_t             req_op,
	input l2_pkg::l2_addr_t            req_address,
	input l2_pkg::way_t                req_l1_way,
	output logic                       resp_valid,
	output l2_pkg::pci_op_t            resp_op,
	output l2_pkg::l2_addr_t           resp_address,
	output l2_pkg::resp_status_t       resp_status,
	output l2_pkg::way_t               resp_way,
	output l2_pkg::l2_tag_t            resp_evict_tag,
	output logic                       resp_l1_valid,
	output l2_pkg::way_t               resp_l1_way,
	output l2_pkg::l2_tag_t            resp_l1_tag);

	tag_dir_if tag_dir();
	dir_resp_if dir_resp();

	l2_tag_stage i_tag_stage(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_address(req_address),
		.req_l1_way(req_l1_way),
		.to_dir(tag_dir.src));

	l2_dir_stage i_dir_stage(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.from_tag(tag_dir.dst),
		.to_resp(dir_resp.src));

	l2_response_stage i_response_stage(
		.clk(clk),
		.reset(reset),
		.stall_pipeline(stall_pipeline),
		.from_dir(dir_resp.dst),
		.resp_valid(resp_valid),
		.resp_op(resp_op),
		.resp_address(resp_address),
		.resp_status(resp_status),
		.resp_way(resp_way),
		.resp_evict_tag(resp_evict_tag),
		.resp_l1_valid(resp_l1_valid),
		.resp_l1_way(resp_l1_way),
		.resp_l1_tag(resp_l1_tag));

endmodule

//--- tests/l2_dir_tb.sv
/*
 * Testbench for the L2 directory pipeline: reference model of tags,
 * dirty bits and L1 directory, directed and random stimulus with
 * stalls, and a response checker that tracks order and latency.
 */

`timescale 1ns/1ps

module l2_dir_tb;
	import l2_pkg::*;

	typedef struct packed {
		pci_op_t op;
		l2_addr_t address;
		resp_status_t status;
		way_t way;
		l2_tag_t evict_tag;
		logic l1_valid;
		way_t l1_way;
		l2_tag_t l1_tag;
		int issue_edge;
	} expected_t;

	logic clk;
	logic reset;
	logic stall_pipeline;
	logic req_valid;
	pci_op_t req_op;
	l2_addr_t req_address;
	way_t req_l1_way;
	logic resp_valid;
	pci_op_t resp_op;
	l2_addr_t resp_address;
	resp_status_t resp_status;
	way_t resp_way;
	l2_tag_t resp_evict_tag;
	logic resp_l1_valid;
	way_t resp_l1_way;
	l2_tag_t resp_l1_tag;

	// Reference copy of the cache state
	l2_tag_t m_tag[l2_num_sets][l2_num_ways];
	logic m_valid[l2_num_sets][l2_num_ways];
	logic m_dirty[l2_num_sets][l2_num_ways];
	way_t m_rr[l2_num_sets];
	logic m_dir_valid[l2_num_sets][l2_num_ways];
	way_t m_dir_way[l2_num_sets][l2_num_ways];
	l2_tag_t m_dir_tag[l2_num_sets][l2_num_ways];

	expected_t expected_q[$];
	int unstalled_edges;
	logic [31:0] rng_state;

	tb_clock_gen i_clock_gen(.clk(clk));

	l2_dir_top i_dut(.*);

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("error at %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_echo(input pci_op_t got_op, input l2_addr_t got_address,
			input pci_op_t exp_op, input l2_addr_t exp_address);
		if (got_op !== exp_op || got_address !== exp_address)
			report_error($sformatf("response for %s 0x%03h, expected %s 0x%03h",
				got_op.name(), got_address, exp_op.name(), exp_address));
	endtask

	task automatic check_status(input resp_status_t got, input way_t got_way,
			input resp_status_t exp, input way_t exp_way);
		if (got !== exp || got_way !== exp_way)
			report_error($sformatf("status %s way %0d, expected %s way %0d",
				got.name(), got_way, exp.name(), exp_way));
	endtask

	task automatic check_evict(input l2_tag_t got, input l2_tag_t exp);
		if (got !== exp)
			report_error($sformatf("evict tag 0x%02h, expected 0x%02h", got, exp));
	endtask

	// Way and tag of an L1 entry only mean something when it is valid
	task automatic check_l1(input logic got_valid, input way_t got_way, input l2_tag_t got_tag,
			input logic exp_valid, input way_t exp_way, input l2_tag_t exp_tag);
		if (got_valid !== exp_valid || (exp_valid && (got_way !== exp_way || got_tag !== exp_tag)))
			report_error($sformatf("L1 entry %b/%0d/0x%02h, expected %b/%0d/0x%02h",
				got_valid, got_way, got_tag, exp_valid, exp_way, exp_tag));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic l2_addr_t line_addr(input int tag, input int set);
		return {l2_tag_t'(tag), l2_set_t'(set)};
	endfunction

	// Returns the expected response of one request and applies it to the model in issue order
	function automatic expected_t model_access(input pci_op_t op, input l2_addr_t address,
			input way_t l1_way);
		expected_t result;
		int s;
		l2_tag_t tag;
		logic hit;
		way_t hit_way;
		way_t rw;
		way_t line;
		s = address[l2_set_width - 1:0];
		tag = address[addr_width - 1:l2_set_width];
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < l2_num_ways; w++)
		begin
			if (!hit && m_valid[s][w] && m_tag[s][w] == tag)
			begin
				hit = 1'b1;
				hit_way = way_t'(w);
			end
		end
		rw = m_rr[s];
		line = hit ? hit_way : rw;
		result = '0;
		result.op = op;
		result.address = address;
		result.way = line;
		if (hit)
			result.status = status_hit;
		else if (op == op_fill && m_valid[s][rw] && m_dirty[s][rw])
		begin
			result.status = status_fill_writeback;
			result.evict_tag = m_tag[s][rw];
		end
		else if (op == op_fill)
			result.status = status_fill;
		else
			result.status = status_miss;
		result.l1_valid = m_dir_valid[s][line];
		result.l1_way = m_dir_way[s][line];
		result.l1_tag = m_dir_tag[s][line];

		if (op == op_fill && !hit)
		begin
			m_tag[s][rw] = tag;
			m_valid[s][rw] = 1'b1;
			m_dirty[s][rw] = 1'b0;
			m_rr[s] = rw + 2'd1;
		end
		if (op == op_store && hit)
			m_dirty[s][hit_way] = 1'b1;
		if (hit || op == op_fill)
		begin
			m_dir_valid[s][line] = 1'b1;
			m_dir_way[s][line] = l1_way;
			m_dir_tag[s][line] = tag;
		end
		return result;
	endfunction

	function automatic logic [31:0] output_snapshot();
		return {resp_valid, resp_op, resp_address, resp_status, resp_way, resp_evict_tag,
			resp_l1_valid, resp_l1_way, resp_l1_tag};
	endfunction

	// A request counts only when it meets an edge with the stall low
	task automatic drive_cycle(input logic valid, input pci_op_t op, input l2_addr_t address,
			input way_t l1_way, input logic stall);
		expected_t entry;
		@(posedge clk);
		#0.5;
		req_valid = valid;
		req_op = op;
		req_address = address;
		req_l1_way = l1_way;
		stall_pipeline = stall;
		if (valid && !stall)
		begin
			entry = model_access(op, address, l1_way);
			entry.issue_edge = unstalled_edges + 1;
			expected_q.push_back(entry);
		end
	endtask

	task automatic issue_request(input pci_op_t op, input l2_addr_t address, input way_t l1_way);
		drive_cycle(1'b1, op, address, l1_way, 1'b0);
	endtask

	task automatic wait_drain(input int max_cycles);
		int waited;
		waited = 0;
		while (expected_q.size() != 0)
		begin
			if (waited == max_cycles)
			begin
				$display("timeout: %0d responses never arrived", expected_q.size());
				abort_run();
			end
			drive_cycle(1'b0, op_load, '0, '0, 1'b0);
			waited++;
		end
	endtask

	always @(posedge clk)
	begin
		if (!stall_pipeline)
			unstalled_edges++;
	end

	// The response register reloads on every unstalled edge
	always @(negedge clk)
	begin : compare_responses
		expected_t exp;
		if (!reset && resp_valid === 1'b1 && !stall_pipeline)
		begin
			if (expected_q.size() == 0)
			begin
				$display("a response arrived with no request outstanding");
				abort_run();
			end
			exp = expected_q.pop_front();
			check_echo(resp_op, resp_address, exp.op, exp.address);
			check_status(resp_status, resp_way, exp.status, exp.way);
			check_evict(resp_evict_tag, exp.evict_tag);
			check_l1(resp_l1_valid, resp_l1_way, resp_l1_tag, exp.l1_valid, exp.l1_way,
				exp.l1_tag);
			if (unstalled_edges != exp.issue_edge + 3)
				report_error($sformatf("response after %0d unstalled cycles, expected 3",
					unstalled_edges - exp.issue_edge));
		end
	end

	initial
	begin : stimulus
		int issued;
		int waited;
		logic [31:0] r;
		logic [31:0] held;
		reset = 1'b1;
		stall_pipeline = 1'b0;
		req_valid = 1'b0;
		req_op = op_load;
		req_address = '0;
		req_l1_way = '0;
		rng_state = 32'd15863;
		unstalled_edges = 0;
		for (int s = 0; s < l2_num_sets; s++)
		begin
			m_rr[s] = '0;
			for (int w = 0; w < l2_num_ways; w++)
			begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_dir_valid[s][w] = 1'b0;
				m_dir_way[s][w] = '0;
				m_dir_tag[s][w] = '0;
			end
		end
		repeat (4) @(posedge clk);
		#0.5;
		reset = 1'b0;

		repeat (8)
		begin
			@(negedge clk);
			if (resp_valid !== 1'b0)
				report_error("resp_valid is not low while idle after reset");
		end
		for (int i = 0; i < 4; i++)
			issue_request(op_load, line_addr(i * 13, i * 5), way_t'(i));
		wait_drain(20);

		// Five fills in one set wrap the round-robin back to way 0
		for (int t = 1; t <= 5; t++)
			issue_request(op_fill, line_addr(t, 5), way_t'(t));
		for (int t = 5; t >= 1; t--)
			issue_request(op_load, line_addr(t, 5), 2'd0);
		wait_drain(20);

		// Dirty eviction, clean eviction, then a fill that hits
		for (int t = 1; t <= 4; t++)
			issue_request(op_fill, line_addr(t, 9), 2'd0);
		issue_request(op_store, line_addr(1, 9), 2'd0);
		issue_request(op_fill, line_addr(5, 9), 2'd1);
		issue_request(op_fill, line_addr(6, 9), 2'd2);
		issue_request(op_fill, line_addr(5, 9), 2'd3);
		wait_drain(20);

		issue_request(op_fill, line_addr(7, 12), 2'd2);
		issue_request(op_load, line_addr(7, 12), 2'd3);
		issue_request(op_store, line_addr(7, 12), 2'd1);
		issue_request(op_load, line_addr(7, 12), 2'd0);
		wait_drain(20);

		// Stall with requests in flight and a request held on the inputs
		for (int i = 0; i < 3; i++)
			issue_request(op_load, line_addr(i + 2, 5), way_t'(i));
		drive_cycle(1'b1, op_fill, line_addr(9, 5), 2'd3, 1'b1);
		held = output_snapshot();
		repeat (4)
		begin
			drive_cycle(1'b1, op_fill, line_addr(9, 5), 2'd3, 1'b1);
			if (output_snapshot() !== held)
				report_error("outputs changed while the pipeline was stalled");
		end
		for (int i = 3; i < 6; i++)
			issue_request(op_store, line_addr(i, 9), way_t'(i));
		wait_drain(20);

		issued = 0;
		while (issued < 400)
		begin
			r = next_random();
			if (r[2:0] == 3'd0)
				drive_cycle(r[3], op_fill, line_addr(r[8:6], 3), r[11:10], 1'b1);
			else if (r[2:0] == 3'd1)
				drive_cycle(1'b0, op_load, '0, '0, 1'b0);
			else
			begin
				issue_request(pci_op_t'(r[5:4] == 2'd3 ? 2'd0 : r[5:4]),
					line_addr(r[8:6], r[9] ? 3 : 14), r[11:10]);
				issued++;
			end
		end

		waited = 0;
		while (expected_q.size() != 0 && waited < 40)
		begin
			drive_cycle(1'b0, op_load, '0, '0, 1'b0);
			waited++;
		end
		// A duplicated last response would show up within the pipeline depth
		repeat (4)
			drive_cycle(1'b0, op_load, '0, '0, 1'b0);

		if (expected_q.size() == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("timeout: %0d responses still outstanding at the end", expected_q.size());
			abort_run();
		end
	end

endmodule

//--- tests/tb_clock_gen.sv
/*
 * Testbench clock source with a 4 ns period.
 */

`timescale 1ns/1ps

module tb_clock_gen(
	output logic clk);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

endmodule
